//--- compile.f
rtl/boot_pkg.sv
rtl/serial_byte_if.sv
rtl/uart_rx_core.sv
rtl/uart_tx_core.sv
rtl/boot_sequencer.sv
rtl/uart_boot_top.sv
dv/boot_assertions.sv
dv/tb_uart_boot.sv

//--- Makefile
TOP := tb_uart_boot

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module uart_boot_top \
		rtl/boot_pkg.sv rtl/serial_byte_if.sv rtl/uart_rx_core.sv \
		rtl/uart_tx_core.sv rtl/boot_sequencer.sv rtl/uart_boot_top.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then \
		echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_uart_boot.sv
// One serial host at CLKS_PER_BIT, APB slave with 0 to 3 wait states, memory of 16 words only
`timescale 1ns/1ps
`default_nettype none

module tb_uart_boot import boot_pkg::*; ();

    typedef struct packed {
        logic [23:0] tok;     // Reply token, first char on top, zero for a silent host
        wcount_t     size;    // Word count minus one, as sent
        int          nwords;  // Words actually sent
    } row_t;

    localparam int          NUM_ROWS = 5;
    localparam word_t       LCG_SEED = 32'hb7d954c0;
    localparam logic [23:0] TOK_ACK  = {CH_A, CH_C, CH_K};
    localparam row_t        ROWS [NUM_ROWS] = '{
        '{24'h000000, 18'd0, 1},            // No reply, boot on timeout
        '{TOK_ACK, 18'd2, 3},
        '{{CH_A, 8'h58, CH_K}, 18'd1, 2},   // "AXK" then header again
        '{TOK_ACK, 18'd0, 1},
        '{TOK_ACK, 18'd5, 6}
    };

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        uart_rx = 1'b1;  // Line idles high
    logic        pready = 1'b0;
    logic        uart_tx;
    logic        boot_reset_core;
    logic        psel;
    logic        penable;
    word_t       paddr;
    word_t       pwdata;

    byte_t       tx_q[$];         // Bytes decoded from uart_tx_o
    int          tx_rd = 0;       // Next byte to check
    word_t       wr_addr_q[$];    // Completed APB writes
    word_t       wr_data_q[$];
    word_t       mem [16];
    word_t       exp_words[$];
    word_t       rnd_data = LCG_SEED;
    word_t       rnd_apb = LCG_SEED ^ 32'h5a5a5a5a;  // Separate stream for wait states
    int          wait_left = 0;
    logic        psel_seen = 1'b0;
    int unsigned cyc = 0;
    int unsigned cycle_limit = 0;

    uart_boot_top dut_i (
        .clk (clk), .rst (rst),
        .uart_rx_i (uart_rx), .uart_tx_o (uart_tx),
        .boot_reset_core_o (boot_reset_core),
        .paddr_o (paddr), .pwdata_o (pwdata),
        .psel_o (psel), .penable_o (penable), .pready_i (pready)
    );

    bind boot_sequencer boot_assertions u_asrt (.*);

    initial begin : clock_gen
        forever #2 clk = ~clk;  // 4 ns period
    end

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Serial bytes in the table, doubled, plus one timeout per row
    function automatic int unsigned run_limit();
        int unsigned bytes;
        bytes = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            bytes = bytes + 3;                                // Header
            if (ROWS[r].tok != 24'd0) begin
                bytes = bytes + 12 + 4 * ROWS[r].nwords;      // Token, size, KCA, data, ACK
                if (ROWS[r].tok != TOK_ACK) bytes = bytes + 6;
            end
        end
        return bytes * 10 * CLKS_PER_BIT * 2 + BOOT_TIMEOUT_CYCLES * NUM_ROWS;
    endfunction

    task automatic report_fail();
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        report_fail();
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_byte(input string name, input byte_t exp, input byte_t got);
        if (got !== exp) begin
            $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, got);
            report_fail();
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t got);
        if (got !== exp) begin
            $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, got);
            report_fail();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERR t=%0t %s exp=%b act=%b", $time, name, exp, got);
            report_fail();
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cycle_limit != 0 && cyc >= cycle_limit)
            fail_now("Run exceeded its cycle limit, DUT stopped responding");
    end

    // ------------------------------------------------------------------------
    // Serial line model
    // ------------------------------------------------------------------------
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_token(input logic [23:0] t);
        send_byte(t[23:16]);
        send_byte(t[15:8]);
        send_byte(t[7:0]);
    endtask

    task automatic expect_token(input logic [23:0] t);
        while (tx_q.size() < tx_rd + 3) @(posedge clk);
        check_byte("uart_tx_o", t[23:16], tx_q[tx_rd]);
        check_byte("uart_tx_o", t[15:8], tx_q[tx_rd + 1]);
        check_byte("uart_tx_o", t[7:0], tx_q[tx_rd + 2]);
        tx_rd = tx_rd + 3;
    endtask

    // Mid-bit decoder of the DUT transmit line
    initial begin : tx_decode
        byte_t b;
        forever begin
            @(posedge clk);
            if (!rst && uart_tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(posedge clk);
                if (uart_tx !== 1'b0) fail_now("Start bit on uart_tx_o ended early");
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(posedge clk);
                    b[i] = uart_tx;
                end
                repeat (CLKS_PER_BIT) @(posedge clk);
                if (uart_tx !== 1'b1) fail_now("No stop bit on uart_tx_o");
                tx_q.push_back(b);
            end
        end
    end

    // ------------------------------------------------------------------------
    // APB memory, random wait states
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            pready    <= 1'b0;
            psel_seen <= 1'b0;
            for (int i = 0; i < 16; i++) mem[i] <= ~word_t'(i);  // Address-dependent fill
        end else if (psel && !penable) begin                      // Setup cycle
            rnd_apb    = lcg_next(rnd_apb);
            wait_left  = int'(rnd_apb[31:30]);
            pready    <= (rnd_apb[31:30] == 2'd0);
            psel_seen <= 1'b1;
        end else if (psel && penable) begin
            if (pready) begin
                if (paddr[31:6] != 26'd0) fail_now("APB write outside the 16-word memory");
                mem[paddr[5:2]] <= pwdata;
                wr_addr_q.push_back(paddr);
                wr_data_q.push_back(pwdata);
                pready <= 1'b0;
            end else begin
                wait_left = wait_left - 1;
                pready   <= (wait_left == 0);
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        rst     <= 1'b1;
        uart_rx <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic wait_core_release();
        while (boot_reset_core !== 1'b0) @(posedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Table loop
    // ------------------------------------------------------------------------
    initial begin : run
        row_t        row;
        int unsigned rel_cyc;
        int          wr_base;
        cycle_limit = run_limit();
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = ROWS[r];
            apply_reset();
            rel_cyc = cyc;
            wr_base = wr_addr_q.size();
            expect_token({CH_U, CH_S, CH_B});
            check_bit("boot_reset_core_o", 1'b1, boot_reset_core);
            if (row.tok == 24'd0) begin
                wait_core_release();
                check_bit("timeout_elapsed", 1'b1, (cyc - rel_cyc) >= BOOT_TIMEOUT_CYCLES);
                check_bit("psel_o", 1'b0, psel_seen);
            end else begin
                send_token(row.tok);
                if (row.tok != TOK_ACK) begin
                    expect_token({CH_U, CH_S, CH_B});  // Header resent
                    send_token(TOK_ACK);
                end
                send_byte(row.size[7:0]);  // Low byte first
                send_byte(row.size[15:8]);
                send_byte(byte_t'(row.size[17:16]));
                expect_token({CH_K, CH_C, CH_A});
                exp_words.delete();
                for (int i = 0; i < row.nwords; i++) begin
                    rnd_data = lcg_next(rnd_data);
                    exp_words.push_back(rnd_data);
                    for (int k = 0; k < 4; k++) send_byte(rnd_data[k*8 +: 8]);
                    while (wr_addr_q.size() < wr_base + i + 1) @(posedge clk);  // Host waits
                end
                expect_token(TOK_ACK);
                check_bit("boot_reset_core_o", 1'b1, boot_reset_core);  // Stop bit not over
                wait_core_release();
                check_bit("uart_tx_o", 1'b1, uart_tx);
                check_word("write_count", word_t'(row.nwords),
                           word_t'(wr_addr_q.size() - wr_base));
                for (int i = 0; i < row.nwords; i++) begin
                    check_word("paddr_o", word_t'(4 * i), wr_addr_q[wr_base + i]);
                    check_word("pwdata_o", exp_words[i], wr_data_q[wr_base + i]);
                    check_word("mem", exp_words[i], mem[i]);
                end
            end
        end
        repeat (4) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/boot_assertions.sv
// Bound into boot_sequencer by port names; all checks are idle while rst is high
`timescale 1ns/1ps
`default_nettype none

module boot_assertions import boot_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  boot_reset_core_o,
    input word_t paddr_o,
    input word_t pwdata_o,
    input logic  psel_o,
    input logic  penable_o,
    input logic  pready_i
);

    // ------------------------------------------------------------------------
    // APB write handshake
    // ------------------------------------------------------------------------
    a_enable_after_setup: assert property (@(posedge clk) disable iff (rst)
        $rose(penable_o) |-> $past(psel_o && !penable_o))  // Setup must come first
        else $error("penable_o rose without a setup cycle");

    // Address and data held through wait states
    a_stable_in_wait: assert property (@(posedge clk) disable iff (rst)
        (psel_o && penable_o && !pready_i) |=> ($stable(paddr_o) && $stable(pwdata_o)))
        else $error("paddr_o or pwdata_o changed during a stalled access");

    // Core release is final until the next reset
    a_core_stays_released: assert property (@(posedge clk) disable iff (rst)
        !boot_reset_core_o |=> !boot_reset_core_o)
        else $error("boot_reset_core_o rose again without rst");

endmodule

`default_nettype wire

//--- rtl/uart_boot_top.sv
// Single clock domain; the serial input is synchronized inside, APB pslverr is not observed
`timescale 1ns/1ps
`default_nettype none

module uart_boot_top (
    input  logic        clk,
    input  logic        rst,
    // Serial line
    input  logic        uart_rx_i,
    output logic        uart_tx_o,
    // Core control
    output logic        boot_reset_core_o,
    // APB write master
    output logic [31:0] paddr_o,
    output logic [31:0] pwdata_o,
    output logic        psel_o,
    output logic        penable_o,
    input  logic        pready_i
);

    // ------------------------------------------------------------------------
    // Byte link between the serial parts and the sequencer
    // ------------------------------------------------------------------------
    serial_byte_if link_if ();

    uart_rx_core u_rx (
        .clk  (clk),
        .rst  (rst),
        .rx_i (uart_rx_i),
        .link (link_if.rx_side)
    );

    uart_tx_core u_tx (
        .clk  (clk),
        .rst  (rst),
        .tx_o (uart_tx_o),
        .link (link_if.tx_side)
    );

    // Protocol and memory writes
    boot_sequencer u_seq (
        .clk               (clk),
        .rst               (rst),
        .link              (link_if.ctrl),
        .boot_reset_core_o (boot_reset_core_o),
        .paddr_o           (paddr_o),
        .pwdata_o          (pwdata_o),
        .psel_o            (psel_o),
        .penable_o         (penable_o),
        .pready_i          (pready_i)
    );

endmodule

`default_nettype wire

//--- rtl/boot_sequencer.sv
// Writes only full words from address 0; bytes arriving during a stalled APB access are lost
`timescale 1ns/1ps
`default_nettype none

module boot_sequencer import boot_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    serial_byte_if.ctrl    link,
    output logic           boot_reset_core_o,  // Holds the core until DONE
    // APB write master
    output word_t          paddr_o,
    output word_t          pwdata_o,
    output logic           psel_o,
    output logic           penable_o,
    input  logic           pready_i
);

    boot_state_e          state_q;
    logic [1:0]           chr_idx_q;   // Character in a three-char token
    logic [1:0]           byte_idx_q;  // Size or data byte
    wcount_t              size_q;      // Word count minus one
    wcount_t              word_cnt_q;  // Words written so far
    word_t                addr_q;
    word_t                wdata_q;
    logic [TIMEOUT_W-1:0] tmo_cnt_q;
    logic                 tmo_hit;
    logic                 send_state;
    logic                 tx_fire;
    logic                 rst_core_q;

    // Token characters, by state and position
    function automatic byte_t tok_char(input boot_state_e st, input logic [1:0] idx);
        byte_t c;
        case (st)
            SEND_HDR: c = (idx == 2'd0) ? CH_U : (idx == 2'd1) ? CH_S : CH_B;
            SEND_KCA: c = (idx == 2'd0) ? CH_K : (idx == 2'd1) ? CH_C : CH_A;
            default:  c = (idx == 2'd0) ? CH_A : (idx == 2'd1) ? CH_C : CH_K;  // "ACK"
        endcase
        return c;
    endfunction

    // ------------------------------------------------------------------------
    // Transmit request, only while the transmitter is free
    // ------------------------------------------------------------------------
    assign send_state    = (state_q == SEND_HDR) || (state_q == SEND_KCA) ||
                           (state_q == SEND_ACK);
    assign tx_fire       = send_state && !link.tx_busy;
    assign link.tx_start = tx_fire;
    assign link.tx_data  = tok_char(state_q, chr_idx_q);

    // Timeout, counts only while waiting for the first 'A'
    always_ff @(posedge clk) begin
        if (rst || state_q != WAIT_ACK || chr_idx_q != 2'd0) tmo_cnt_q <= '0;
        else tmo_cnt_q <= tmo_cnt_q + TIMEOUT_W'(1);
    end

    assign tmo_hit = (tmo_cnt_q == TIMEOUT_W'(BOOT_TIMEOUT_CYCLES - 1));

    // ------------------------------------------------------------------------
    // Protocol FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= IDLE;
            chr_idx_q  <= '0;
            byte_idx_q <= '0;
            word_cnt_q <= '0;
            addr_q     <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    chr_idx_q  <= '0;
                    byte_idx_q <= '0;
                    word_cnt_q <= '0;
                    addr_q     <= '0;
                    state_q    <= SEND_HDR;
                end
                SEND_HDR, SEND_KCA, SEND_ACK: begin
                    if (tx_fire) begin
                        if (chr_idx_q == 2'd2) begin
                            chr_idx_q  <= '0;
                            byte_idx_q <= '0;
                            case (state_q)
                                SEND_HDR: state_q <= WAIT_ACK;
                                SEND_KCA: state_q <= GET_DATA;
                                default:  state_q <= DRAIN;
                            endcase
                        end else begin
                            chr_idx_q <= chr_idx_q + 2'd1;
                        end
                    end
                end
                WAIT_ACK: begin
                    if (link.rx_valid) begin
                        if (link.rx_data == tok_char(WAIT_ACK, chr_idx_q)) begin
                            if (chr_idx_q == 2'd2) begin
                                chr_idx_q <= '0;
                                state_q   <= GET_SIZE;
                            end else begin
                                chr_idx_q <= chr_idx_q + 2'd1;
                            end
                        end else begin
                            state_q <= IDLE;  // Wrong char, header again
                        end
                    end else if (tmo_hit) begin
                        state_q <= DONE;  // No host, boot what is there
                    end
                end
                GET_SIZE: begin
                    if (link.rx_valid) begin
                        case (byte_idx_q)
                            2'd0:    size_q[7:0]                <= link.rx_data;
                            2'd1:    size_q[15:8]               <= link.rx_data;
                            default: size_q[WORD_COUNT_W-1:16] <= link.rx_data[1:0];
                        endcase
                        if (byte_idx_q == 2'd2) state_q <= SEND_KCA;
                        else byte_idx_q <= byte_idx_q + 2'd1;
                    end
                end
                GET_DATA: begin
                    if (link.rx_valid) begin
                        wdata_q[byte_idx_q*8 +: 8] <= link.rx_data;  // Little endian
                        byte_idx_q                 <= byte_idx_q + 2'd1;  // Wraps to 0
                        if (byte_idx_q == 2'd3) state_q <= APB_SETUP;
                    end
                end
                APB_SETUP: state_q <= APB_ACCESS;
                APB_ACCESS: begin
                    if (pready_i) begin
                        addr_q <= addr_q + word_t'(4);
                        if (word_cnt_q == size_q) begin
                            state_q <= SEND_ACK;  // Last word written
                        end else begin
                            word_cnt_q <= word_cnt_q + wcount_t'(1);
                            state_q    <= GET_DATA;
                        end
                    end
                end
                DRAIN: if (!link.tx_busy) state_q <= DONE;
                DONE:  state_q <= DONE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Core released one cycle after DONE
    always_ff @(posedge clk) begin
        if (rst) rst_core_q <= 1'b1;
        else rst_core_q <= (state_q != DONE);
    end

    assign boot_reset_core_o = rst_core_q;

    // APB, write only
    assign psel_o    = (state_q == APB_SETUP) || (state_q == APB_ACCESS);
    assign penable_o = (state_q == APB_ACCESS);
    assign paddr_o   = addr_q;
    assign pwdata_o  = wdata_q;  // Stable until the next data byte

endmodule

`default_nettype wire

//--- rtl/uart_tx_core.sv
// 8N1 only; requests while busy are not queued and must be held off by the caller
`timescale 1ns/1ps
`default_nettype none

module uart_tx_core import boot_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 tx_o,  // Serial line, idles high
    serial_byte_if.tx_side       link
);

    uart_bit_e            phase_q;
    logic [BIT_CNT_W-1:0] cnt_q;
    logic [2:0]           bit_idx_q;  // Data bit in flight
    logic [9:0]           frame_q;    // Stop, data, start; bit 0 on the line
    logic                 bit_end;

    assign bit_end = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));

    // ------------------------------------------------------------------------
    // Frame shifter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q   <= IDLE_BIT;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            frame_q   <= '1;  // Line high out of reset
        end else begin
            if (phase_q == IDLE_BIT) begin
                cnt_q     <= '0;
                bit_idx_q <= '0;
                if (link.tx_start) begin
                    frame_q <= {1'b1, link.tx_data, 1'b0};
                    phase_q <= START_BIT;  // Start bit next cycle
                end
            end else if (bit_end) begin
                cnt_q   <= '0;
                frame_q <= {1'b1, frame_q[9:1]};  // Ones fill in behind
                case (phase_q)
                    START_BIT: phase_q <= DATA_BITS;
                    DATA_BITS: begin
                        if (bit_idx_q == 3'd7) phase_q <= STOP_BIT;
                        else bit_idx_q <= bit_idx_q + 3'd1;
                    end
                    default:   phase_q <= IDLE_BIT;  // Stop bit done
                endcase
            end else begin
                cnt_q <= cnt_q + BIT_CNT_W'(1);
            end
        end
    end

    assign tx_o         = frame_q[0];
    assign link.tx_busy = (phase_q != IDLE_BIT);  // Falls as the stop bit ends

endmodule

`default_nettype wire

//--- rtl/uart_rx_core.sv
// 8N1 only, no parity, no break detection; a bad stop bit drops the byte silently
`timescale 1ns/1ps
`default_nettype none

module uart_rx_core import boot_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx_i,  // Asynchronous serial line
    serial_byte_if.rx_side       link
);

    logic [1:0]           sync_q;     // Two-flop synchronizer
    logic                 rx_line;
    uart_bit_e            phase_q;
    logic [BIT_CNT_W-1:0] cnt_q;      // Clocks within the bit
    logic [2:0]           bit_idx_q;  // Data bit number
    byte_t                shift_q;    // LSB arrives first
    logic                 valid_q;

    assign rx_line = sync_q[1];

    // ------------------------------------------------------------------------
    // Frame sampling, mid-bit
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q    <= 2'b11;  // Idle line level
            phase_q   <= IDLE_BIT;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], rx_i};
            valid_q <= 1'b0;
            case (phase_q)
                IDLE_BIT: begin
                    cnt_q <= '0;
                    if (!rx_line) phase_q <= START_BIT;  // Falling edge
                end
                START_BIT: begin
                    // Half a bit in, line must still be low
                    if (cnt_q == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                        phase_q   <= rx_line ? IDLE_BIT : DATA_BITS;  // Glitch goes back
                    end else begin
                        cnt_q <= cnt_q + BIT_CNT_W'(1);
                    end
                end
                DATA_BITS: begin
                    if (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
                        cnt_q   <= '0;
                        shift_q <= {rx_line, shift_q[7:1]};
                        if (bit_idx_q == 3'd7) phase_q <= STOP_BIT;
                        else bit_idx_q <= bit_idx_q + 3'd1;
                    end else begin
                        cnt_q <= cnt_q + BIT_CNT_W'(1);
                    end
                end
                STOP_BIT: begin
                    if (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
                        cnt_q   <= '0;
                        phase_q <= IDLE_BIT;
                        valid_q <= rx_line;  // Framing error gives no strobe
                    end else begin
                        cnt_q <= cnt_q + BIT_CNT_W'(1);
                    end
                end
                default: phase_q <= IDLE_BIT;
            endcase
        end
    end

    assign link.rx_data  = shift_q;  // Held until the next frame shifts in
    assign link.rx_valid = valid_q;

endmodule

`default_nettype wire

//--- rtl/serial_byte_if.sv
// Byte handshake only: rx_valid has no back-pressure, tx_start is legal only while tx_busy is low
`timescale 1ns/1ps
`default_nettype none

interface serial_byte_if import boot_pkg::*; ();

    // Receive direction
    byte_t rx_data;   // Valid with rx_valid
    logic  rx_valid;  // One-cycle pulse per frame

    // Transmit direction
    byte_t tx_data;
    logic  tx_start;  // Single cycle request
    logic  tx_busy;   // High from the cycle after tx_start to end of stop bit

    // Serial receiver drives the byte and its strobe
    modport rx_side (output rx_data, rx_valid);

    // Serial transmitter takes the byte, reports busy
    modport tx_side (input tx_data, tx_start, output tx_busy);

    // Boot sequencer
    modport ctrl (
        input  rx_data, rx_valid, tx_busy,
        output tx_data, tx_start
    );

endinterface

`default_nettype wire

//--- rtl/boot_pkg.sv
// Fixed timing only: bit rate and boot timeout are set here and no core parameters override them
`default_nettype none

package boot_pkg;

    // ------------------------------------------------------------------------
    // Timing
    // ------------------------------------------------------------------------
    localparam int unsigned CLKS_PER_BIT        = 8;     // Clocks per serial bit
    localparam int unsigned BIT_CNT_W           = $clog2(CLKS_PER_BIT);
    localparam int unsigned BOOT_TIMEOUT_CYCLES = 2000;  // Wait for first 'A'
    localparam int unsigned TIMEOUT_W           = $clog2(BOOT_TIMEOUT_CYCLES);
    localparam int unsigned WORD_COUNT_W        = 18;    // Image size counter

    // ------------------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------------------
    typedef logic [7:0]              byte_t;    // One serial byte
    typedef logic [31:0]             word_t;    // Memory word, also the address
    typedef logic [WORD_COUNT_W-1:0] wcount_t;  // Words minus one

    // Protocol characters
    localparam byte_t CH_U = 8'h55;
    localparam byte_t CH_S = 8'h53;
    localparam byte_t CH_B = 8'h42;
    localparam byte_t CH_A = 8'h41;
    localparam byte_t CH_C = 8'h43;
    localparam byte_t CH_K = 8'h4B;

    // Boot sequencer states
    typedef enum logic [3:0] {
        IDLE,        // Clear counters, start header
        SEND_HDR,    // "USB"
        WAIT_ACK,    // Expect "ACK" or time out
        GET_SIZE,    // Three size bytes, low first
        SEND_KCA,    // Size acknowledge
        GET_DATA,    // Four bytes per word
        APB_SETUP,
        APB_ACCESS,
        SEND_ACK,    // Image done
        DRAIN,       // Let the last stop bit finish
        DONE         // Core released
    } boot_state_e;

    // Frame phases, receiver and transmitter alike
    typedef enum logic [1:0] {IDLE_BIT, START_BIT, DATA_BITS, STOP_BIT} uart_bit_e;

endpackage

`default_nettype wire
